// File: pport_subsys.f
src/avr_io_pkg.sv
src/pport_pkg.sv
src/rsnc_vect.sv
src/pport.sv
src/io_rd_mux.sv
src/pport_subsys.sv
tests/tb_pport_subsys.sv

// File: Bender.yml
package:
  name: pport_subsys

sources:
  - src/avr_io_pkg.sv
  - src/pport_pkg.sv
  - src/rsnc_vect.sv
  - src/pport.sv
  - src/io_rd_mux.sv
  - src/pport_subsys.sv
  - target: test
    files:
      - tests/tb_pport_subsys.sv

// File: tests/tb_pport_subsys.sv
`default_nettype none

module tb_pport_subsys
   import avr_io_pkg::*;
   import pport_pkg::*;
();

   localparam int n_dir     = 60;    // Upper bound on directed operations
   localparam int n_rand    = 200;
   localparam int wd_cycles = 200 + 20 * (n_dir + n_rand);

   logic       cp2;
   logic       ireset;
   io_req_t    io_req;
   dm_req_t    dm_req;
   rd_rsp_t    io_rsp;
   rd_rsp_t    dm_rsp;
   byte_t      porta;
   byte_t      ddra;
   byte_t      pina;
   logic [5:0] pinb;

   // Register model and expected outputs of the current cycle
   byte_t      m_porta;
   byte_t      m_ddra;
   byte_t      m_pina;
   logic [5:0] m_pinb;
   rd_rsp_t    exp_io;
   rd_rsp_t    exp_dm;
   byte_t      exp_porta;
   byte_t      exp_ddra;
   logic       chk_en;
   int         n_err;
   integer     seed;

   pport_subsys #(
      .a_rs_mode (pport_fre),
      .b_rs_mode (pport_rre)
   ) u_pport_subsys (
      .cp2    (cp2),
      .ireset (ireset),
      .io_req (io_req),
      .dm_req (dm_req),
      .io_rsp (io_rsp),
      .dm_rsp (dm_rsp),
      .porta  (porta),
      .ddra   (ddra),
      .pina   (pina),
      .pinb   (pinb)
   );

   initial
   begin
      cp2 = 1'b0;
      forever #10 cp2 = ~cp2;
   end

   // ************************************************************************
   // Reference model
   // ************************************************************************

   // Expected read response of one bus, adr is the full bus address
   function automatic rd_rsp_t ref_rsp(bit dm_bus, logic re, logic sel, dm_adr_t adr,
                                       byte_t r_porta, byte_t r_ddra, byte_t r_pina,
                                       logic [5:0] r_pinb);
      rd_rsp_t r;
      dm_adr_t base;
      r    = '0;
      base = dm_bus ? IO_DM_OFFSET : 8'h00;
      if (re && (sel || !dm_bus))
      begin
         r.out_en = 1'b1;
         if (adr == base + PORTA_ADR)
            r.rdata = r_porta;
         else if (adr == base + DDRA_ADR)
            r.rdata = r_ddra;
         else if (adr == base + PINA_ADR)
            r.rdata = r_pina;
         else if (!dm_bus && adr == base + PINB_ADR)
            r.rdata = {2'b00, r_pinb};   // Port B only in I/O space
         else
            r.out_en = 1'b0;
      end
      return r;
   endfunction

   task automatic check(input string name, input logic [7:0] got, input logic [7:0] want);
      if (got !== want)
      begin
         n_err++;
         $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, want);
         $display("Errors found");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   // Compare at the rising edge, half a cycle after the drive
   always @(posedge cp2)
   begin
      if (chk_en)
      begin
         check("io_rsp.out_en", 8'(io_rsp.out_en), 8'(exp_io.out_en));
         check("io_rsp.rdata", io_rsp.rdata, exp_io.rdata);
         check("dm_rsp.out_en", 8'(dm_rsp.out_en), 8'(exp_dm.out_en));
         check("dm_rsp.rdata", dm_rsp.rdata, exp_dm.rdata);
         check("porta", porta, exp_porta);
         check("ddra", ddra, exp_ddra);
      end
   end

   // ************************************************************************
   // Stimulus
   // ************************************************************************

   task automatic apply(input io_req_t io, input dm_req_t dm);
      @(negedge cp2);
      io_req    <= io;
      dm_req    <= dm;
      exp_io    = ref_rsp(1'b0, io.iore, 1'b1, dm_adr_t'(io.adr),
                          m_porta, m_ddra, m_pina, m_pinb);
      exp_dm    = ref_rsp(1'b1, dm.ramre, dm.dm_sel, dm.ramadr,
                          m_porta, m_ddra, m_pina, m_pinb);
      exp_porta = m_porta;   // Writes show after this edge
      exp_ddra  = m_ddra;
      chk_en    = 1'b1;
      if (io.iowe && io.adr == PORTA_ADR)
         m_porta = io.wdata;
      else if (dm.ramwe && dm.dm_sel && dm.ramadr == IO_DM_OFFSET + PORTA_ADR)
         m_porta = dm.wdata;
      if (io.iowe && io.adr == DDRA_ADR)
         m_ddra = io.wdata;
      else if (dm.ramwe && dm.dm_sel && dm.ramadr == IO_DM_OFFSET + DDRA_ADR)
         m_ddra = dm.wdata;
   endtask

   task automatic idle();
      apply('0, '0);
   endtask

   task automatic io_access(input io_adr_t adr, input byte_t data, input bit write);
      io_req_t io;
      io       = '0;
      io.adr   = adr;
      io.wdata = data;
      io.iowe  = write;
      io.iore  = !write;
      apply(io, '0);
   endtask

   task automatic dm_access(input dm_adr_t adr, input byte_t data, input bit write,
                            input logic sel);
      dm_req_t dm;
      dm        = '0;
      dm.ramadr = adr;
      dm.wdata  = data;
      dm.ramwe  = write;
      dm.ramre  = !write;
      dm.dm_sel = sel;
      apply('0, dm);
   endtask

   // New pin values, then wait out the synchronizer
   task automatic set_pins(input byte_t a, input logic [5:0] b);
      idle();
      pina <= a;
      pinb <= b;
      repeat (3) idle();
      m_pina = a;
      m_pinb = b;
   endtask

   function automatic io_adr_t rand_io_adr();
      int k;
      k = {$random(seed)} % 8;
      case (k)
         0: return PORTA_ADR;
         1: return DDRA_ADR;
         2: return PINA_ADR;
         3: return PORTB_ADR;
         4: return DDRB_ADR;
         5: return PINB_ADR;
         default: return io_adr_t'($random(seed));
      endcase
   endfunction

   initial
   begin
      repeat (wd_cycles) @(posedge cp2);
      $display("Timeout: the run did not finish within %0d cycles", wd_cycles);
      $display("Errors found");
      $fatal(1, "Watchdog expired");
   end

   initial
   begin
      io_req_t io;
      dm_req_t dm;
      int      op;
      seed    = 32'h0c09_de82;
      n_err   = 0;
      chk_en  = 1'b0;
      ireset  = 1'b0;
      io_req  = '0;
      dm_req  = '0;
      pina    = '0;
      pinb    = '0;
      m_porta = '0;
      m_ddra  = '0;
      m_pina  = '0;
      m_pinb  = '0;
      repeat (4) @(negedge cp2);
      ireset <= 1'b1;

      // Reset values
      idle();
      io_access(PORTA_ADR, 8'h00, 1'b0);
      io_access(DDRA_ADR, 8'h00, 1'b0);
      dm_access(IO_DM_OFFSET + PORTA_ADR, 8'h00, 1'b0, 1'b1);

      // I/O writes and read back
      for (int n = 0; n < 4; n++)
      begin
         io_access(PORTA_ADR, byte_t'($random(seed)), 1'b1);
         io_access(DDRA_ADR, byte_t'($random(seed)), 1'b1);
         io_access(PORTA_ADR, 8'h00, 1'b0);
         io_access(DDRA_ADR, 8'h00, 1'b0);
      end

      // DM window, with and without dm_sel
      for (int n = 0; n < 2; n++)
      begin
         dm_access(IO_DM_OFFSET + PORTA_ADR, byte_t'($random(seed)), 1'b1, 1'b1);
         dm_access(IO_DM_OFFSET + PORTA_ADR, 8'h00, 1'b0, 1'b1);
         dm_access(IO_DM_OFFSET + PORTA_ADR, byte_t'($random(seed)), 1'b1, 1'b0);
         dm_access(IO_DM_OFFSET + PORTA_ADR, 8'h00, 1'b0, 1'b0);
         dm_access(IO_DM_OFFSET + PORTA_ADR, 8'h00, 1'b0, 1'b1);
      end

      // Pins through both buses
      for (int n = 0; n < 2; n++)
      begin
         set_pins(byte_t'($random(seed)), 6'($random(seed)));
         io_access(PINA_ADR, 8'h00, 1'b0);
         io_access(PINB_ADR, 8'h00, 1'b0);
         dm_access(IO_DM_OFFSET + PINA_ADR, 8'h00, 1'b0, 1'b1);
         dm_access(IO_DM_OFFSET + PINB_ADR, 8'h00, 1'b0, 1'b1);
      end

      // Port B has no PORTB or DDRB
      io_access(PORTB_ADR, 8'hA5, 1'b1);
      io_access(DDRB_ADR, 8'h5A, 1'b1);
      io_access(PORTB_ADR, 8'h00, 1'b0);
      io_access(DDRB_ADR, 8'h00, 1'b0);
      dm_access(IO_DM_OFFSET + PORTB_ADR, 8'hC3, 1'b1, 1'b1);
      dm_access(IO_DM_OFFSET + DDRB_ADR, 8'h00, 1'b0, 1'b1);
      io_access(PORTA_ADR, 8'h00, 1'b0);
      io_access(DDRA_ADR, 8'h00, 1'b0);

      // Random mix of both buses
      for (int n = 0; n < n_rand; n++)
      begin
         op = {$random(seed)} % 16;
         if (op == 0)
            set_pins(byte_t'($random(seed)), 6'($random(seed)));
         else
         begin
            io.adr    = rand_io_adr();
            io.wdata  = byte_t'($random(seed));
            io.iore   = 1'($random(seed));
            io.iowe   = 1'($random(seed));
            dm.ramadr = op[0] ? dm_adr_t'($random(seed)) : IO_DM_OFFSET + rand_io_adr();
            dm.wdata  = byte_t'($random(seed));
            dm.ramre  = 1'($random(seed));
            dm.ramwe  = 1'($random(seed));
            dm.dm_sel = 1'($random(seed));
            if (io.iowe && dm.ramwe)
               dm.ramwe = 1'b0;   // Core never writes on both buses at once
            apply(io, dm);
         end
      end

      idle();
      @(negedge cp2);
      if (n_err == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

// File: src/pport_subsys.sv
`default_nettype none

module pport_subsys
   import avr_io_pkg::*;
   import pport_pkg::*;
#(
   parameter pport_rs_e a_rs_mode = pport_fre,
   parameter pport_rs_e b_rs_mode = pport_rre
)
(
   input  logic       cp2,
   input  logic       ireset,
   // Core buses
   input  io_req_t    io_req,
   input  dm_req_t    dm_req,
   output rd_rsp_t    io_rsp,
   output rd_rsp_t    dm_rsp,
   // Pins
   output byte_t      porta,
   output byte_t      ddra,
   input  byte_t      pina,
   input  logic [5:0] pinb
);

   rd_rsp_t a_io_rsp;
   rd_rsp_t a_dm_rsp;
   rd_rsp_t b_io_rsp;
   rd_rsp_t b_dm_rsp;

   // ************************************************************************
   // Port A, bidirectional, fully mapped into DM
   // ************************************************************************

   pport #(
      .port_width   (8),
      .port_mode    (pport_bidir),
      .rs_mode      (a_rs_mode),
      .portx_adr    (PORTA_ADR),
      .ddrx_adr     (DDRA_ADR),
      .pinx_adr     (PINA_ADR),
      .portx_dm_loc (1'b1),
      .ddrx_dm_loc  (1'b1),
      .pinx_dm_loc  (1'b1)
   ) u_port_a (
      .cp2    (cp2),
      .ireset (ireset),
      .io_req (io_req),
      .dm_req (dm_req),
      .io_rsp (a_io_rsp),
      .dm_rsp (a_dm_rsp),
      .portx  (porta),
      .ddrx   (ddra),
      .pinx   (pina)
   );

   // Port B, input only, I/O space only
   pport #(
      .port_width   (6),
      .port_mode    (pport_in),
      .rs_mode      (b_rs_mode),
      .portx_adr    (PORTB_ADR),
      .ddrx_adr     (DDRB_ADR),
      .pinx_adr     (PINB_ADR),
      .portx_dm_loc (1'b0),
      .ddrx_dm_loc  (1'b0),
      .pinx_dm_loc  (1'b0)
   ) u_port_b (
      .cp2    (cp2),
      .ireset (ireset),
      .io_req (io_req),
      .dm_req (dm_req),
      .io_rsp (b_io_rsp),
      .dm_rsp (b_dm_rsp),
      .portx  (),   // Tied to zero inside, no output pins on port B
      .ddrx   (),
      .pinx   (pinb)
   );

   io_rd_mux u_rd_mux (
      .a_io   (a_io_rsp),
      .a_dm   (a_dm_rsp),
      .b_io   (b_io_rsp),
      .b_dm   (b_dm_rsp),
      .io_rsp (io_rsp),
      .dm_rsp (dm_rsp)
   );

endmodule

`default_nettype wire

// File: src/io_rd_mux.sv
`default_nettype none

// Merges the read responses of both ports into one per bus
module io_rd_mux
   import avr_io_pkg::*;
(
   input  rd_rsp_t a_io,
   input  rd_rsp_t a_dm,
   input  rd_rsp_t b_io,
   input  rd_rsp_t b_dm,
   output rd_rsp_t io_rsp,
   output rd_rsp_t dm_rsp
);

   rd_rsp_t [3:0] all_rsp;   // Every source, for the checks below

   function automatic rd_rsp_t merge(rd_rsp_t x, rd_rsp_t y);
      rd_rsp_t r;
      r.rdata  = (x.out_en ? x.rdata : '0) | (y.out_en ? y.rdata : '0);
      r.out_en = x.out_en | y.out_en;
      return r;
   endfunction

   assign io_rsp = merge(a_io, b_io);
   assign dm_rsp = merge(a_dm, b_dm);

   assign all_rsp = {b_dm, b_io, a_dm, a_io};

   // ************************************************************************
   // Bus checks
   // ************************************************************************

   // Overlapping register maps would show up as two drivers
   always_comb
   begin
      a_one_io: assert final ($isunknown({a_io.out_en, b_io.out_en})
                              || $onehot0({a_io.out_en, b_io.out_en}))
         else $error("io_rd_mux: both ports drive the I/O read bus");
      a_one_dm: assert final ($isunknown({a_dm.out_en, b_dm.out_en})
                              || $onehot0({a_dm.out_en, b_dm.out_en}))
         else $error("io_rd_mux: both ports drive the DM read bus");
   end

   // Idle sources keep their data at zero
   always_comb
   begin
      for (int k = 0; k < 4; k++)
      begin
         a_idle_zero: assert final ($isunknown(all_rsp[k].out_en)
                                    || all_rsp[k].out_en
                                    || (all_rsp[k].rdata == '0))
            else $error("io_rd_mux: source %0d has data without out_en", k);
      end
   end

endmodule

`default_nettype wire

// File: src/pport.sv
`default_nettype none

module pport
   import avr_io_pkg::*;
   import pport_pkg::*;
#(
   parameter int          port_width   = 8,
   parameter pport_mode_e port_mode    = pport_bidir,
   parameter pport_rs_e   rs_mode      = pport_fre,
   parameter io_adr_t     portx_adr    = PORTA_ADR,
   parameter io_adr_t     ddrx_adr     = DDRA_ADR,
   parameter io_adr_t     pinx_adr     = PINA_ADR,
   parameter bit          portx_dm_loc = 1'b0,
   parameter bit          ddrx_dm_loc  = 1'b0,
   parameter bit          pinx_dm_loc  = 1'b0
)
(
   input  logic                  cp2,
   input  logic                  ireset,
   input  io_req_t               io_req,
   input  dm_req_t               dm_req,
   output rd_rsp_t               io_rsp,
   output rd_rsp_t               dm_rsp,
   output logic [port_width-1:0] portx,
   output logic [port_width-1:0] ddrx,
   input  logic [port_width-1:0] pinx
);

   // Register table, entry 0 is PORTx, 1 is DDRx, 2 is PINx
   localparam int n_reg = 3;
   localparam int n_wr  = 2;   // PINx is read only

   localparam io_adr_t [n_reg-1:0] reg_adr    = {pinx_adr, ddrx_adr, portx_adr};
   localparam bit      [n_reg-1:0] reg_dm_loc = {pinx_dm_loc, ddrx_dm_loc, portx_dm_loc};
   localparam bit      [n_reg-1:0] reg_impl   = {impl_pinx(port_mode),
                                                 impl_ddrx(port_mode),
                                                 impl_portx(port_mode)};

   logic [n_reg-1:0][port_width-1:0] reg_val;   // Contents as seen by reads
   logic [port_width-1:0]            pin_sync;
   logic [n_reg-1:0]                 io_hit;    // Address decode per bus
   logic [n_reg-1:0]                 dm_hit;
   logic [n_wr-1:0]                  io_we;
   logic [n_wr-1:0]                  dm_we;

   // ************************************************************************
   // Address decode
   // ************************************************************************

   generate
      for (genvar k = 0; k < n_reg; k++)
      begin : g_dec
         assign io_hit[k] = reg_impl[k] && (io_req.adr == reg_adr[k]);
         assign dm_hit[k] = reg_impl[k] && reg_dm_loc[k] && dm_req.dm_sel
                            && (dm_req.ramadr == io_to_dm(reg_adr[k]));
      end
   endgenerate

   assign io_we = io_hit[n_wr-1:0] & {n_wr{io_req.iowe}};
   assign dm_we = dm_hit[n_wr-1:0] & {n_wr{dm_req.ramwe}};

   // ************************************************************************
   // PORTx and DDRx
   // ************************************************************************

   generate
      for (genvar i = 0; i < n_wr; i++)
      begin : g_wr
         if (reg_impl[i])
         begin : g_impl
            logic [port_width-1:0] q;

            always_ff @(posedge cp2 or negedge ireset)
            begin
               if (!ireset)
                  q <= '0;
               else if (io_we[i])
                  q <= io_req.wdata[port_width-1:0];
               else if (dm_we[i])
                  q <= dm_req.wdata[port_width-1:0];
            end

            assign reg_val[i] = q;
         end
         else
         begin : g_none
            assign reg_val[i] = '0;   // Not present in this mode
         end
      end
   endgenerate

   // Pins
   generate
      if (reg_impl[2])
      begin : g_pin_sync
         rsnc_vect #(
            .width      (port_width),
            .fall_first (rs_mode == pport_fre)
         ) u_rsnc (
            .cp2    (cp2),
            .ireset (ireset),
            .di     (pinx),
            .dout   (pin_sync)
         );
      end
      else
      begin : g_no_pin_sync
         assign pin_sync = '0;
      end
   endgenerate

   assign reg_val[2] = pin_sync;

   // ************************************************************************
   // Read responses
   // ************************************************************************

   always_comb
   begin
      io_rsp = '0;
      dm_rsp = '0;
      for (int k = 0; k < n_reg; k++)
      begin
         if (io_req.iore && io_hit[k])
         begin
            io_rsp.rdata  = byte_t'(reg_val[k]);   // Zero-extend narrow ports
            io_rsp.out_en = 1'b1;
         end
         if (dm_req.ramre && dm_hit[k])
         begin
            dm_rsp.rdata  = byte_t'(reg_val[k]);
            dm_rsp.out_en = 1'b1;
         end
      end
   end

   assign portx = reg_val[0];
   assign ddrx  = reg_val[1];

   // The core never issues both bus writes to one register at once
   a_no_dual_wr: assert property (@(posedge cp2) disable iff (!ireset)
                                  !(|(io_we & dm_we)))
      else $error("pport: I/O and DM write to the same register in one cycle");

endmodule

`default_nettype wire

// File: src/rsnc_vect.sv
`default_nettype none

// Two-flop synchronizer for a vector of asynchronous pins
module rsnc_vect #(
   parameter int width      = 8,
   parameter bit fall_first = 1'b0   // First stage on the falling edge
)
(
   input  logic             cp2,
   input  logic             ireset,
   input  logic [width-1:0] di,
   output logic [width-1:0] dout
);

   logic [width-1:0] stg1;   // May go metastable
   logic [width-1:0] stg2;

   generate
      if (fall_first)
      begin : g_fall
         always_ff @(negedge cp2 or negedge ireset)
         begin
            if (!ireset)
               stg1 <= '0;
            else
               stg1 <= di;
         end
      end
      else
      begin : g_rise
         always_ff @(posedge cp2 or negedge ireset)
         begin
            if (!ireset)
               stg1 <= '0;
            else
               stg1 <= di;
         end
      end
   endgenerate

   always_ff @(posedge cp2 or negedge ireset)
   begin
      if (!ireset)
         stg2 <= '0;
      else
         stg2 <= stg1;
   end

   assign dout = stg2;

endmodule

`default_nettype wire

// File: src/pport_pkg.sv
`default_nettype none

package pport_pkg;

   // Direction of a parallel port
   typedef enum logic [1:0] {
      pport_bidir,
      pport_in,
      pport_out
   } pport_mode_e;

   // Clock edge of the first synchronizer stage
   typedef enum logic {
      pport_rre,   // Rising edge
      pport_fre    // Falling edge, saves half a cycle of latency
   } pport_rs_e;

   // Mode  | Registers
   // bidir | PORTx DDRx PINx
   // in    | PINx
   // out   | PORTx

   function automatic bit impl_portx(pport_mode_e mode);
      return (mode == pport_bidir) || (mode == pport_out);
   endfunction

   function automatic bit impl_ddrx(pport_mode_e mode);
      return mode == pport_bidir;
   endfunction

   function automatic bit impl_pinx(pport_mode_e mode);
      return (mode == pport_bidir) || (mode == pport_in);
   endfunction

endpackage

`default_nettype wire

// File: src/avr_io_pkg.sv
`default_nettype none

package avr_io_pkg;

   // ************************************************************************
   // Bus widths
   // ************************************************************************

   typedef logic [5:0] io_adr_t;   // I/O space address
   typedef logic [7:0] dm_adr_t;   // Data memory address
   typedef logic [7:0] byte_t;     // Data bus value

   // One I/O bus cycle
   typedef struct packed {
      io_adr_t adr;
      byte_t   wdata;
      logic    iore;
      logic    iowe;
   } io_req_t;

   // One DM bus cycle, dm_sel flags the mapped I/O window
   typedef struct packed {
      dm_adr_t ramadr;
      byte_t   wdata;
      logic    ramre;
      logic    ramwe;
      logic    dm_sel;
   } dm_req_t;

   typedef struct packed {
      byte_t rdata;
      logic  out_en;   // Source drives the read bus
   } rd_rsp_t;

   // ************************************************************************
   // Register map
   // ************************************************************************

   localparam dm_adr_t IO_DM_OFFSET = 8'h20;   // I/O space starts here in DM

   localparam io_adr_t PORTA_ADR = 6'h1B;
   localparam io_adr_t DDRA_ADR  = 6'h1A;
   localparam io_adr_t PINA_ADR  = 6'h19;
   localparam io_adr_t PORTB_ADR = 6'h18;   // Port B has no output register
   localparam io_adr_t DDRB_ADR  = 6'h17;
   localparam io_adr_t PINB_ADR  = 6'h16;

   // DM location of an I/O register
   function automatic dm_adr_t io_to_dm(io_adr_t adr);
      return dm_adr_t'(adr) + IO_DM_OFFSET;
   endfunction

endpackage

`default_nettype wire
